// File: rtl/bus_pkg.sv
package bus_pkg;

	// ------------------------------------------------------------
	// register bus and stream word
	// ------------------------------------------------------------
	localparam int WORD_W = 32;
	typedef logic [WORD_W-1:0] word_t;

	localparam int REG_ADDR_W = 5;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// ------------------------------------------------------------
	// register map
	// ------------------------------------------------------------
	localparam reg_addr_t REG_CTRL        = 5'h00;
	localparam reg_addr_t REG_KEY_EVEN_LO = 5'h04;
	localparam reg_addr_t REG_KEY_EVEN_HI = 5'h08;
	localparam reg_addr_t REG_KEY_ODD_LO  = 5'h0C;
	localparam reg_addr_t REG_KEY_ODD_HI  = 5'h10;
	localparam reg_addr_t REG_STATUS      = 5'h14;  // read only
	localparam reg_addr_t REG_BLOCK_COUNT = 5'h18;  // read only

	localparam int CTRL_ENABLE     = 0;
	localparam int CTRL_KEY_ODD    = 1;
	localparam int CTRL_MODE       = 2;  // set selects descrambling
	localparam int CTRL_SOFT_RESET = 3;  // never stored, reads back as zero
	localparam int STAT_BUSY       = 0;

	localparam int FIFO_IN_DEPTH  = 16;
	localparam int FIFO_OUT_DEPTH = 16;

endpackage

// File: rtl/csa_pkg.sv
package csa_pkg;

	// ------------------------------------------------------------
	// cipher block and keystream
	// ------------------------------------------------------------
	localparam int BLOCK_W = 64;

	// the first word of a pair sits in the low half
	typedef logic [BLOCK_W-1:0] block_t;

	// Galois feedback mask, applied when a one is shifted out
	localparam block_t LFSR_POLY = 64'hD800000000000000;

	localparam int LFSR_STEPS = 64;  // shifts per block

	// ------------------------------------------------------------
	// modes and sequencer states
	// ------------------------------------------------------------
	typedef enum logic
	{
		MODE_BYPASS     = 1'b0,
		MODE_DESCRAMBLE = 1'b1
	} csa_mode_t;

	typedef enum logic [1:0]
	{
		CS_IDLE  = 2'd0,
		CS_FETCH = 2'd1,
		CS_RUN   = 2'd2,
		CS_STORE = 2'd3
	} calc_state_t;

endpackage

// File: rtl/axis_in_fifo.sv
`timescale 1ns/100ps

module axis_in_fifo
	import bus_pkg::*;
(
	input  logic  aclk,
	input  logic  core_rst_n,
	input  logic  s_tvalid,
	input  word_t s_tdata,
	input  logic  s_tlast,
	output logic  s_tready,
	input  logic  in_ren,
	output word_t in_rdata,
	output logic  in_rlast,
	output logic  in_pair_ready
);

	word_t mem_data [FIFO_IN_DEPTH];
	logic  mem_last [FIFO_IN_DEPTH];

	logic [$clog2(FIFO_IN_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_IN_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_IN_DEPTH):0]   count;
	logic                             push;
	logic                             pop;

	assign push = s_tvalid && s_tready;
	assign pop  = in_ren && (count != '0);  // a pop on an empty buffer is dropped

	assign s_tready      = (count != FIFO_IN_DEPTH);
	assign in_pair_ready = (count >= 2);

	// head word is presented before it is popped
	assign in_rdata = mem_data[rd_ptr];
	assign in_rlast = mem_last[rd_ptr];

	always_ff @(posedge aclk)
	begin
		if (!core_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;  // pointers wrap with the buffer
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge aclk)
	begin
		if (push)
		begin
			mem_data[wr_ptr] <= s_tdata;
			mem_last[wr_ptr] <= s_tlast;
		end
	end

endmodule

// File: rtl/axis_out_fifo.sv
`timescale 1ns/100ps

module axis_out_fifo
	import bus_pkg::*;
(
	input  logic  aclk,
	input  logic  core_rst_n,
	input  logic  out_wen,
	input  word_t out_wdata,
	input  logic  out_wlast,
	output logic  out_pair_room,
	output logic  m_tvalid,
	output word_t m_tdata,
	output logic  m_tlast,
	input  logic  m_tready
);

	word_t mem_data [FIFO_OUT_DEPTH];
	logic  mem_last [FIFO_OUT_DEPTH];

	logic [$clog2(FIFO_OUT_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_OUT_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_OUT_DEPTH):0]   count;
	logic                              pop;
	logic                              head_free;
	logic                              mem_rd;
	logic                              mem_wr;

	// ------------------------------------------------------------
	// head register control
	// ------------------------------------------------------------
	assign pop       = m_tvalid && m_tready;
	assign head_free = !m_tvalid || pop;  // head may take a new word at this edge

	assign mem_rd = head_free && (count != '0);
	assign mem_wr = out_wen && !(head_free && (count == '0));  // otherwise it goes straight to the head

	// the head register is a slot of its own, so the buffer count alone decides room
	assign out_pair_room = (count <= FIFO_OUT_DEPTH - 2);

	always_ff @(posedge aclk)
	begin
		if (!core_rst_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			m_tvalid <= 1'b0;
		end
		else
		begin
			if (mem_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (mem_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({mem_wr, mem_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (head_free)
				m_tvalid <= (count != '0) || out_wen;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (mem_wr)
		begin
			mem_data[wr_ptr] <= out_wdata;
			mem_last[wr_ptr] <= out_wlast;
		end
		if (mem_rd)
		begin
			m_tdata <= mem_data[rd_ptr];  // older words leave first
			m_tlast <= mem_last[rd_ptr];
		end
		else if (head_free && out_wen)
		begin
			m_tdata <= out_wdata;
			m_tlast <= out_wlast;
		end
	end

endmodule

// File: rtl/csa_calc.sv
`timescale 1ns/100ps

module csa_calc
	import csa_pkg::*;
(
	input  logic   aclk,
	input  logic   rst_n,
	input  logic   calc_load,
	input  block_t calc_key,
	input  logic   calc_start,
	input  block_t calc_din,
	output logic   calc_done,
	output block_t calc_dout
);

	block_t     lfsr;
	block_t     din_q;
	logic       busy;
	logic [5:0] step_cnt;

	// one Galois shift to the right
	function automatic block_t lfsr_step(input block_t s);
		block_t n;
		n = {1'b0, s[BLOCK_W-1:1]};
		if (s[0])
			n = n ^ LFSR_POLY;
		return n;
	endfunction

	always_ff @(posedge aclk)
	begin
		if (!rst_n)
		begin
			lfsr      <= '0;
			busy      <= 1'b0;
			step_cnt  <= '0;
			calc_done <= 1'b0;
		end
		else
		begin
			calc_done <= 1'b0;
			if (calc_load)
				lfsr <= calc_key;
			else if (calc_start)
			begin
				lfsr     <= lfsr_step(lfsr);  // the start cycle already does the first shift
				busy     <= 1'b1;
				step_cnt <= 6'd1;
			end
			else if (busy)
			begin
				lfsr     <= lfsr_step(lfsr);
				step_cnt <= step_cnt + 1'b1;
				if (step_cnt == 6'(LFSR_STEPS - 1))
				begin
					busy      <= 1'b0;
					calc_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge aclk)
	begin
		if (calc_start)
			din_q <= calc_din;
		if (busy && step_cnt == 6'(LFSR_STEPS - 1))
			calc_dout <= din_q ^ lfsr_step(lfsr);  // xor with the state after the last shift
	end

endmodule

// File: rtl/csa_ram.sv
`timescale 1ns/100ps

module csa_ram
	import bus_pkg::*, csa_pkg::*;
(
	input  logic      aclk,
	input  logic      rst_n,
	input  logic      reg_wen,
	input  reg_addr_t reg_waddr,
	input  word_t     reg_wdata,
	input  logic      reg_ren,
	input  reg_addr_t reg_raddr,
	output word_t     reg_rdata,
	output logic      core_rst_n,
	input  logic      in_pair_ready,
	output logic      in_ren,
	input  word_t     in_rdata,
	input  logic      in_rlast,
	input  logic      out_pair_room,
	output logic      out_wen,
	output word_t     out_wdata,
	output logic      out_wlast
);

	logic        ctrl_enable;
	logic        ctrl_key_odd;
	csa_mode_t   ctrl_mode;
	word_t       key_even_lo;
	word_t       key_even_hi;
	word_t       key_odd_lo;
	word_t       key_odd_hi;
	word_t       block_count;
	logic        soft_rst;
	word_t       rd_mux;

	calc_state_t state;
	csa_mode_t   blk_mode;
	logic        pkt_start;
	logic        fetch_sel;
	logic        store_sel;
	block_t      blk;
	logic        blk_last;

	logic        calc_load;
	block_t      calc_key;
	logic        calc_start;
	logic        calc_done;
	block_t      calc_dout;

	// ------------------------------------------------------------
	// register file
	// ------------------------------------------------------------
	always_ff @(posedge aclk)
	begin
		if (!rst_n)
		begin
			ctrl_enable  <= 1'b0;
			ctrl_key_odd <= 1'b0;
			ctrl_mode    <= MODE_BYPASS;
			key_even_lo  <= '0;
			key_even_hi  <= '0;
			key_odd_lo   <= '0;
			key_odd_hi   <= '0;
			soft_rst     <= 1'b0;
		end
		else
		begin
			soft_rst <= 1'b0;
			if (reg_wen)
			begin
				case (reg_waddr)
					REG_CTRL:
					begin
						ctrl_enable  <= reg_wdata[CTRL_ENABLE];
						ctrl_key_odd <= reg_wdata[CTRL_KEY_ODD];
						ctrl_mode    <= csa_mode_t'(reg_wdata[CTRL_MODE]);
						soft_rst     <= reg_wdata[CTRL_SOFT_RESET];
					end
					REG_KEY_EVEN_LO: key_even_lo <= reg_wdata;
					REG_KEY_EVEN_HI: key_even_hi <= reg_wdata;
					REG_KEY_ODD_LO:  key_odd_lo  <= reg_wdata;
					REG_KEY_ODD_HI:  key_odd_hi  <= reg_wdata;
					default: ;  // status, count and holes take no writes
				endcase
			end
		end
	end

	assign core_rst_n = rst_n && !soft_rst;  // FIFOs and sequencer restart on either

	always_comb
	begin
		rd_mux = '0;
		case (reg_raddr)
			REG_CTRL:
			begin
				rd_mux[CTRL_ENABLE]  = ctrl_enable;
				rd_mux[CTRL_KEY_ODD] = ctrl_key_odd;
				rd_mux[CTRL_MODE]    = ctrl_mode;
			end
			REG_KEY_EVEN_LO: rd_mux = key_even_lo;
			REG_KEY_EVEN_HI: rd_mux = key_even_hi;
			REG_KEY_ODD_LO:  rd_mux = key_odd_lo;
			REG_KEY_ODD_HI:  rd_mux = key_odd_hi;
			REG_STATUS:      rd_mux[STAT_BUSY] = (state != CS_IDLE);
			REG_BLOCK_COUNT: rd_mux = block_count;
			default:         rd_mux = '0;
		endcase
	end

	always_ff @(posedge aclk)
	begin
		if (!rst_n)
			reg_rdata <= '0;
		else if (reg_ren)
			reg_rdata <= rd_mux;  // held until the next read
	end

	// ------------------------------------------------------------
	// block sequencer
	// ------------------------------------------------------------
	assign in_ren    = (state == CS_FETCH);  // one pop in each of the two fetch cycles
	assign calc_key  = ctrl_key_odd ? {key_odd_hi, key_odd_lo} : {key_even_hi, key_even_lo};
	assign calc_load = (state == CS_FETCH) && !fetch_sel && pkt_start
		&& (blk_mode == MODE_DESCRAMBLE);

	always_ff @(posedge aclk)
	begin
		if (!core_rst_n)
		begin
			state       <= CS_IDLE;
			blk_mode    <= MODE_BYPASS;
			pkt_start   <= 1'b1;
			fetch_sel   <= 1'b0;
			store_sel   <= 1'b0;
			calc_start  <= 1'b0;
			out_wen     <= 1'b0;
			block_count <= '0;
		end
		else
		begin
			calc_start <= 1'b0;
			out_wen    <= 1'b0;
			case (state)
				CS_IDLE:
				begin
					if (ctrl_enable && in_pair_ready)
					begin
						state    <= CS_FETCH;
						blk_mode <= ctrl_mode;  // mode stays fixed for the whole block
					end
				end
				CS_FETCH:
				begin
					fetch_sel <= !fetch_sel;
					if (fetch_sel)
					begin
						pkt_start <= in_rlast;  // the block after a tlast starts a new packet
						if (blk_mode == MODE_DESCRAMBLE)
						begin
							calc_start <= 1'b1;
							state      <= CS_RUN;
						end
						else
							state <= CS_STORE;
					end
				end
				CS_RUN:
				begin
					if (calc_done)
						state <= CS_STORE;
				end
				CS_STORE:
				begin
					if (store_sel)
					begin
						out_wen     <= 1'b1;
						store_sel   <= 1'b0;
						state       <= CS_IDLE;
						block_count <= block_count + 1'b1;
					end
					else if (out_pair_room)
					begin
						out_wen   <= 1'b1;
						store_sel <= 1'b1;
					end
				end
				default: state <= CS_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk)
	begin
		if (state == CS_FETCH)
		begin
			if (fetch_sel)
			begin
				blk[BLOCK_W-1:WORD_W] <= in_rdata;
				blk_last              <= in_rlast;
			end
			else
				blk[WORD_W-1:0] <= in_rdata;
		end
		if (state == CS_RUN && calc_done)
			blk <= calc_dout;
		if (state == CS_STORE)
		begin
			out_wdata <= store_sel ? blk[BLOCK_W-1:WORD_W] : blk[WORD_W-1:0];
			out_wlast <= store_sel && blk_last;  // tlast only ever rides on the second word
		end
	end

	csa_calc csa_calc_inst
	(
		.aclk       (aclk),
		.rst_n      (core_rst_n),
		.calc_load  (calc_load),
		.calc_key   (calc_key),
		.calc_start (calc_start),
		.calc_din   (blk),
		.calc_done  (calc_done),
		.calc_dout  (calc_dout)
	);

endmodule

// File: rtl/csa_wrap.sv
`timescale 1ns/100ps

module csa_wrap
	import bus_pkg::*;
(
	input  logic      aclk,
	input  logic      rst_n,
	input  logic      reg_wen,
	input  reg_addr_t reg_waddr,
	input  word_t     reg_wdata,
	input  logic      reg_ren,
	input  reg_addr_t reg_raddr,
	output word_t     reg_rdata,
	input  logic      s_tvalid,
	input  word_t     s_tdata,
	input  logic      s_tlast,
	output logic      s_tready,
	output logic      m_tvalid,
	output word_t     m_tdata,
	output logic      m_tlast,
	input  logic      m_tready
);

	logic  core_rst_n;
	logic  in_pair_ready;
	logic  in_ren;
	word_t in_rdata;
	logic  in_rlast;
	logic  out_pair_room;
	logic  out_wen;
	word_t out_wdata;
	logic  out_wlast;

	axis_in_fifo axis_in_fifo_inst
	(
		.aclk          (aclk),
		.core_rst_n    (core_rst_n),
		.s_tvalid      (s_tvalid),
		.s_tdata       (s_tdata),
		.s_tlast       (s_tlast),
		.s_tready      (s_tready),
		.in_ren        (in_ren),
		.in_rdata      (in_rdata),
		.in_rlast      (in_rlast),
		.in_pair_ready (in_pair_ready)
	);

	csa_ram csa_ram_inst
	(
		.aclk          (aclk),
		.rst_n         (rst_n),
		.reg_wen       (reg_wen),
		.reg_waddr     (reg_waddr),
		.reg_wdata     (reg_wdata),
		.reg_ren       (reg_ren),
		.reg_raddr     (reg_raddr),
		.reg_rdata     (reg_rdata),
		.core_rst_n    (core_rst_n),
		.in_pair_ready (in_pair_ready),
		.in_ren        (in_ren),
		.in_rdata      (in_rdata),
		.in_rlast      (in_rlast),
		.out_pair_room (out_pair_room),
		.out_wen       (out_wen),
		.out_wdata     (out_wdata),
		.out_wlast     (out_wlast)
	);

	axis_out_fifo axis_out_fifo_inst
	(
		.aclk          (aclk),
		.core_rst_n    (core_rst_n),
		.out_wen       (out_wen),
		.out_wdata     (out_wdata),
		.out_wlast     (out_wlast),
		.out_pair_room (out_pair_room),
		.m_tvalid      (m_tvalid),
		.m_tdata       (m_tdata),
		.m_tlast       (m_tlast),
		.m_tready      (m_tready)
	);

endmodule

// File: test/csa_wrap_tb.sv
`timescale 1ns/100ps

module csa_wrap_tb
	import bus_pkg::*, csa_pkg::*;
();

	localparam int N_PKT = 54;  // 12 directed, 40 back-pressure, 2 around soft reset

	logic      aclk;
	logic      rst_n;
	logic      reg_wen;
	reg_addr_t reg_waddr;
	word_t     reg_wdata;
	logic      reg_ren;
	reg_addr_t reg_raddr;
	word_t     reg_rdata;
	logic      s_tvalid;
	word_t     s_tdata;
	logic      s_tlast;
	logic      s_tready;
	logic      m_tvalid;
	word_t     m_tdata;
	logic      m_tlast;
	logic      m_tready;

	integer    seed = 32'h018d594a;
	int        plen [N_PKT];
	int        pkt_idx;
	int        total_words;
	int        blocks_sent;
	int        err_data;
	int        err_reg;
	int        err_other;
	logic      gap_en;
	logic      bp_en;
	word_t     exp_data [$];
	logic      exp_last [$];
	word_t     mon_data;
	logic      mon_last;
	word_t     ctrl_val;
	block_t    key_even;
	block_t    key_odd;
	block_t    model_state;

	csa_wrap UUT
	(
		.aclk      (aclk),
		.rst_n     (rst_n),
		.reg_wen   (reg_wen),
		.reg_waddr (reg_waddr),
		.reg_wdata (reg_wdata),
		.reg_ren   (reg_ren),
		.reg_raddr (reg_raddr),
		.reg_rdata (reg_rdata),
		.s_tvalid  (s_tvalid),
		.s_tdata   (s_tdata),
		.s_tlast   (s_tlast),
		.s_tready  (s_tready),
		.m_tvalid  (m_tvalid),
		.m_tdata   (m_tdata),
		.m_tlast   (m_tlast),
		.m_tready  (m_tready)
	);

	initial
	begin
		aclk = 1'b0;
		forever #50 aclk = ~aclk;
	end

	// ------------------------------------------------------------
	// reference model and compare tasks
	// ------------------------------------------------------------
	function automatic block_t csa_ref_block(input block_t din, input block_t key,
		input csa_mode_t mode);
		block_t s;
		int     k;
		if (mode == MODE_BYPASS)
			return din;
		s = key;
		for (k = 0; k < LFSR_STEPS; k++)
			s = s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
		return din ^ s;  // caller recovers the new state as din ^ result
	endfunction

	task automatic check_word(input word_t exp_word, input logic exp_tlast);
		if (m_tdata !== exp_word)
		begin
			err_data++;
			$display("[FAIL] %0t m_tdata expected %h actual %h", $time, exp_word, m_tdata);
		end
		if (m_tlast !== exp_tlast)
		begin
			err_data++;
			$display("[FAIL] %0t m_tlast expected %b actual %b", $time, exp_tlast, m_tlast);
		end
	endtask

	task automatic check_reg(input reg_addr_t addr, input word_t exp_word);
		if (reg_rdata !== exp_word)
		begin
			err_reg++;
			$display("[FAIL] %0t reg_rdata at 0x%h expected %h actual %h", $time, addr,
				exp_word, reg_rdata);
		end
	endtask

	// ------------------------------------------------------------
	// bus and stream drivers
	// ------------------------------------------------------------
	task automatic reg_write(input reg_addr_t addr, input word_t data);
		@(negedge aclk);
		reg_wen   = 1'b1;
		reg_waddr = addr;
		reg_wdata = data;
		@(negedge aclk);
		reg_wen = 1'b0;
		case (addr)  // track what the DUT should now hold
			REG_CTRL:        ctrl_val = data & 32'h7;
			REG_KEY_EVEN_LO: key_even[31:0] = data;
			REG_KEY_EVEN_HI: key_even[63:32] = data;
			REG_KEY_ODD_LO:  key_odd[31:0] = data;
			REG_KEY_ODD_HI:  key_odd[63:32] = data;
			default: ;
		endcase
	endtask

	task automatic read_expect(input reg_addr_t addr, input word_t exp_word);
		@(negedge aclk);
		reg_ren   = 1'b1;
		reg_raddr = addr;
		@(negedge aclk);
		reg_ren = 1'b0;
		check_reg(addr, exp_word);
	endtask

	task automatic send_word(input word_t data, input logic last);
		logic accepted;
		@(negedge aclk);
		if (gap_en && ($unsigned($random(seed)) % 3 == 0))
		begin
			s_tvalid = 1'b0;
			@(negedge aclk);
		end
		s_tvalid = 1'b1;
		s_tdata  = data;
		s_tlast  = last;
		accepted = 1'b0;
		while (!accepted)
		begin
			@(posedge aclk);
			accepted = s_tready;  // value before the edge updates the FIFO count
		end
	endtask

	task automatic send_packet(input logic close_pkt);
		word_t     w [8];
		block_t    din;
		block_t    dout;
		csa_mode_t mode;
		int        n;
		int        b;
		n    = plen[pkt_idx];
		mode = csa_mode_t'(ctrl_val[CTRL_MODE]);
		pkt_idx++;
		if (mode == MODE_DESCRAMBLE)
			model_state = ctrl_val[CTRL_KEY_ODD] ? key_odd : key_even;  // fresh key per packet
		for (b = 0; b < n / 2; b++)
		begin
			w[2*b]     = $random(seed);
			w[2*b + 1] = $random(seed);
			din        = {w[2*b + 1], w[2*b]};
			dout       = csa_ref_block(din, model_state, mode);
			if (mode == MODE_DESCRAMBLE)
				model_state = dout ^ din;
			exp_data.push_back(dout[31:0]);
			exp_last.push_back(1'b0);
			exp_data.push_back(dout[63:32]);
			exp_last.push_back(close_pkt && (b == n / 2 - 1));
			blocks_sent++;
		end
		for (b = 0; b < n; b++)
			send_word(w[b], close_pkt && (b == n - 1));
		@(negedge aclk);
		s_tvalid = 1'b0;
		s_tlast  = 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_data.size() != 0 && cycles < 4000)
		begin
			@(negedge aclk);
			cycles++;
		end
		if (exp_data.size() != 0)
		begin
			err_other++;
			$display("%0t: %0d output words never arrived", $time, exp_data.size());
			exp_data.delete();
			exp_last.delete();
		end
		repeat (2) @(negedge aclk);
	endtask

	// ------------------------------------------------------------
	// output monitor, sink ready and watchdog
	// ------------------------------------------------------------
	always @(posedge aclk)
	begin
		if (m_tvalid && m_tready)
		begin
			if (exp_data.size() == 0)
			begin
				err_other++;
				$display("%0t: output word %h arrived with nothing outstanding", $time, m_tdata);
			end
			else
			begin
				mon_data = exp_data.pop_front();
				mon_last = exp_last.pop_front();
				check_word(mon_data, mon_last);
			end
		end
	end

	always @(negedge aclk)
	begin
		if (bp_en)
			m_tready = ($unsigned($random(seed)) % 4) == 0;
		else
			m_tready = 1'b1;
	end

	initial
	begin
		wait (total_words != 0);
		repeat (total_words * 80 + 2000) @(posedge aclk);
		err_other++;
		$display("watchdog expired before the test sequence completed");
		$display("errors: data %0d, register %0d, other %0d", err_data, err_reg, err_other);
		$display("TEST FAIL");
		$finish;
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial
	begin
		int i;
		rst_n       = 1'b0;
		reg_wen     = 1'b0;
		reg_waddr   = '0;
		reg_wdata   = '0;
		reg_ren     = 1'b0;
		reg_raddr   = '0;
		s_tvalid    = 1'b0;
		s_tdata     = '0;
		s_tlast     = 1'b0;
		m_tready    = 1'b1;
		gap_en      = 1'b0;
		bp_en       = 1'b0;
		ctrl_val    = '0;
		key_even    = '0;
		key_odd     = '0;
		model_state = '0;
		for (i = 0; i < N_PKT; i++)
		begin
			if (i >= 4 && i < 8)
				plen[i] = 4 + 2 * ($unsigned($random(seed)) % 3);  // multi-block packets
			else
				plen[i] = 2 + 2 * ($unsigned($random(seed)) % 4);
			total_words += plen[i];
		end
		repeat (5) @(posedge aclk);
		@(negedge aclk);
		rst_n = 1'b1;
		@(negedge aclk);
		if (!s_tready || m_tvalid || reg_rdata !== '0)
		begin
			err_other++;
			$display("%0t: outputs not at their reset values after reset", $time);
		end

		// register access
		reg_write(REG_KEY_EVEN_LO, 32'h89abcdef);
		reg_write(REG_KEY_EVEN_HI, 32'h01234567);
		reg_write(REG_KEY_ODD_LO, 32'h76543210);
		reg_write(REG_KEY_ODD_HI, 32'hfedcba98);
		reg_write(REG_CTRL, (1 << CTRL_KEY_ODD) | (1 << CTRL_MODE));
		read_expect(REG_CTRL, ctrl_val);
		read_expect(REG_KEY_EVEN_LO, key_even[31:0]);
		read_expect(5'h1c, 32'h0);  // hole in the map
		read_expect(REG_KEY_EVEN_HI, key_even[63:32]);
		read_expect(REG_STATUS, 32'h0);
		read_expect(REG_KEY_ODD_LO, key_odd[31:0]);
		read_expect(REG_BLOCK_COUNT, 32'h0);
		read_expect(REG_KEY_ODD_HI, key_odd[63:32]);

		// bypass, then descrambling with the even key
		reg_write(REG_CTRL, 1 << CTRL_ENABLE);
		repeat (4) send_packet(1'b1);
		wait_drain();
		reg_write(REG_CTRL, (1 << CTRL_ENABLE) | (1 << CTRL_MODE));
		repeat (4) send_packet(1'b1);
		wait_drain();

		// odd key and key changes between packets
		reg_write(REG_CTRL, (1 << CTRL_ENABLE) | (1 << CTRL_MODE) | (1 << CTRL_KEY_ODD));
		send_packet(1'b1);
		wait_drain();
		reg_write(REG_KEY_EVEN_LO, $random(seed));
		reg_write(REG_KEY_EVEN_HI, $random(seed));
		reg_write(REG_CTRL, (1 << CTRL_ENABLE) | (1 << CTRL_MODE));
		send_packet(1'b1);
		wait_drain();
		reg_write(REG_KEY_ODD_LO, $random(seed));
		reg_write(REG_CTRL, (1 << CTRL_ENABLE) | (1 << CTRL_MODE) | (1 << CTRL_KEY_ODD));
		send_packet(1'b1);
		wait_drain();
		reg_write(REG_CTRL, (1 << CTRL_ENABLE) | (1 << CTRL_MODE));
		send_packet(1'b1);
		wait_drain();

		// back-pressure on both sides, the bypass half outruns the sink
		gap_en = 1'b1;
		bp_en  = 1'b1;
		reg_write(REG_CTRL, 1 << CTRL_ENABLE);
		repeat (20) send_packet(1'b1);
		wait_drain();
		reg_write(REG_CTRL, (1 << CTRL_ENABLE) | (1 << CTRL_MODE));
		repeat (20) send_packet(1'b1);
		wait_drain();
		gap_en = 1'b0;
		bp_en  = 1'b0;
		repeat (2) @(negedge aclk);
		read_expect(REG_BLOCK_COUNT, blocks_sent);
		read_expect(REG_STATUS, 32'h0);

		// soft reset while idle, with the last packet left open
		send_packet(1'b0);
		wait_drain();
		reg_write(REG_CTRL, ctrl_val | (1 << CTRL_SOFT_RESET));
		blocks_sent = 0;
		read_expect(REG_CTRL, ctrl_val);
		read_expect(REG_BLOCK_COUNT, 32'h0);
		send_packet(1'b1);
		wait_drain();
		read_expect(REG_BLOCK_COUNT, blocks_sent);

		$display("errors: data %0d, register %0d, other %0d", err_data, err_reg, err_other);
		if (err_data + err_reg + err_other == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: compile.f
rtl/bus_pkg.sv
rtl/csa_pkg.sv
rtl/axis_in_fifo.sv
rtl/axis_out_fifo.sv
rtl/csa_calc.sv
rtl/csa_ram.sv
rtl/csa_wrap.sv
test/csa_wrap_tb.sv
